// ==== test/equihash_cases.txt ====
// hdr0 hdr1 hdr2 hdr3 sol0 sol1 sol2 sol3 mask, all hex
// Solution words hold four 8-bit indices each, lowest byte first; mask bit0 xor, bit1 order, bit2 dup
00000000 ABCD0000 12345678 DEADBEEF 03020100 07060504 0B0A0908 0F0E0D0C 0
00000000 ABCD0000 12345678 DEADBEEF 03020100 07060504 0B0A0908 1F0E0D0C 1
00000000 ABCD0000 12345678 DEADBEEF 03020100 06070504 0B0A0908 0F0E0D0C 2
00000000 ABCD0000 12345678 DEADBEEF 03020300 07060504 0B0A0B08 0F0E0D0C 4
00000000 ABCD0000 12345678 DEADBEEF 03020100 07060404 0B0A0908 0F0E0D0C 7
00000000 ABCD0000 12345678 DEADBEEF 03020100 07060504 0B0A0908 0E1F0D0C 3
00000000 ABCD0000 12345678 DEADBEEF 03020300 07060405 0B0A0B08 0F0E0D0C 6
00000000 00000000 00000000 00000000 13121110 17161514 1B1A1918 1F1E1D1C 0
00000000 00000000 00000000 00000000 8E818F80 8C838D82 8A858B84 88878986 0
00000000 FFFF0000 FFFFFFFF FFFFFFFF F3F2F1F0 F7F6F5F4 FBFAF9F8 FFFEFDFC 0
00000000 00000000 00000000 00000000 8E818F80 8C838D82 8A858B84 90878986 1
00FF1234 55AA8001 0BADF00D CAFEBABE 02010201 04030403 06050605 08070807 4
00FF1234 55AA8001 0BADF00D CAFEBABE 11100503 12111210 21202120 31303130 5
00FF1234 55AA8001 0BADF00D CAFEBABE 11100305 12111210 21202120 31303130 7
00FF1234 55AA8001 0BADF00D CAFEBABE 02010102 04030403 06050605 08070807 6

// ==== vlog.f ====
hw/equihash_pkg.sv
hw/sol_ram.sv
hw/ram_arbiter.sv
hw/sol_loader.sv
hw/index_hasher.sv
hw/sol_checker.sv
hw/equihash_verif_top.sv
test/tb_equihash_verif.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_equihash_verif
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= Test failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/tb_equihash_verif.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_equihash_verif;

  localparam int HASH_ROUNDS  = 3;
  localparam int RST_CYCLES   = 16;
  localparam int CYC_PER_CASE = 60;
  localparam int CYC_MARGIN   = 100;
  localparam int CASE_WORDS   = equihash_pkg::HDR_WORDS + equihash_pkg::SOL_WORDS;

  logic                      i_clk;
  logic                      i_rst;
  equihash_pkg::word_t       i_dat;
  logic                      i_dat_val;
  logic                      i_dat_eop;
  equihash_pkg::check_mask_t o_mask;
  logic                      o_mask_val;
  logic                      o_busy;

  // Eight stream words per case with the header first
  equihash_pkg::word_t       case_words [$];
  equihash_pkg::check_mask_t case_mask  [$];

  integer seed = 35;
  int     num_cases = 0;
  int     cycle_cnt = 0;
  int     cycle_limit = 0;
  int     mask_cnt = 0;
  int     tests_pass = 0;
  int     tests_fail = 0;

  equihash_verif_top #(.HASH_ROUNDS(HASH_ROUNDS)) dut_i (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_dat(i_dat), .i_dat_val(i_dat_val), .i_dat_eop(i_dat_eop),
    .o_mask(o_mask), .o_mask_val(o_mask_val), .o_busy(o_busy)
  );

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout after %0d cycles: the DUT never produced a mask", cycle_cnt);
      $display("Test failed");
      $finish;
    end
  end

  // Every mask pulse is counted so extra or missing pulses show up at the end
  always @(negedge i_clk) begin
    if (!i_rst && o_mask_val === 1'b1) begin
      mask_cnt++;
    end
  end

  task automatic report_result(input string name, input int errs);
    if (errs == 0) begin
      tests_pass++;
      $display("%s: PASS", name);
    end else begin
      tests_fail++;
      $display("%s: FAIL with %0d errors", name, errs);
    end
  endtask

  task automatic load_cases();
    int                        fd;
    int                        n_fields;
    string                     line;
    equihash_pkg::word_t       w [CASE_WORDS];
    equihash_pkg::check_mask_t m;
    fd = $fopen("test/equihash_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file test/equihash_cases.txt");
      tests_fail++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      // Blank lines and comment lines carry no case
      if (line.len() < 2 || line.getc(0) == "/") begin
        continue;
      end
      n_fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                         w[0], w[1], w[2], w[3], w[4], w[5], w[6], w[7], m);
      if (n_fields != CASE_WORDS + 1) begin
        $display("Malformed case line skipped: %s", line);
        tests_fail++;
      end else begin
        for (int k = 0; k < CASE_WORDS; k++) begin
          case_words.push_back(w[k]);
        end
        case_mask.push_back(m);
        num_cases++;
      end
    end
    $fclose(fd);
  endtask

  task automatic check_quiet(input string phase, inout int errs);
    assert (o_mask_val === 1'b0 && o_busy === 1'b0) else begin
      $display("** Error %s: o_mask_val = %h, o_busy = %h, expected 0 and 0",
               phase, o_mask_val, o_busy);
      errs++;
    end
  endtask

  task automatic send_case(input int n);
    int gap;
    for (int w = 0; w < CASE_WORDS; w++) begin
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) begin
        @(posedge i_clk);
        i_dat_val <= 1'b0;
        i_dat_eop <= 1'b0;
      end
      @(posedge i_clk);
      i_dat     <= case_words[n*CASE_WORDS + w];
      i_dat_val <= 1'b1;
      i_dat_eop <= (w == CASE_WORDS - 1);
    end
    @(posedge i_clk);
    i_dat_val <= 1'b0;
    i_dat_eop <= 1'b0;
  endtask

  task automatic wait_mask(input int n);
    int errs;
    errs = 0;
    @(negedge i_clk);
    while (o_mask_val !== 1'b1) begin
      // Busy must hold until the result comes out
      assert (o_busy === 1'b1 || errs > 0) else begin
        $display("** Error case %0d: o_busy = %h before the mask, expected 1", n, o_busy);
        errs++;
      end
      @(negedge i_clk);
    end
    assert (o_mask === case_mask[n]) else begin
      $display("** Error case %0d: o_mask = %h, expected %h", n, o_mask, case_mask[n]);
      errs++;
    end
    assert (o_busy === 1'b0) else begin
      $display("** Error case %0d: o_busy = %h with o_mask_val, expected 0", n, o_busy);
      errs++;
    end
    report_result($sformatf("Case %0d mask %h", n, case_mask[n]), errs);
  endtask

  initial begin
    int errs;
    i_rst     = 1'b1;
    i_dat     = '0;
    i_dat_val = 1'b0;
    i_dat_eop = 1'b0;
    load_cases();
    cycle_limit = num_cases * CYC_PER_CASE + CYC_MARGIN;

    errs = 0;
    for (int c = 0; c < RST_CYCLES - 1; c++) begin
      @(negedge i_clk);
      check_quiet("during reset", errs);
    end
    @(posedge i_clk);
    i_rst <= 1'b0;
    repeat (4) begin
      @(negedge i_clk);
      check_quiet("after reset", errs);
    end
    report_result("Reset outputs", errs);

    for (int n = 0; n < num_cases; n++) begin
      send_case(n);
      wait_mask(n);
    end

    errs = 0;
    repeat (20) @(negedge i_clk);
    assert (mask_cnt == num_cases) else begin
      $display("Expected %0d mask pulses but counted %0d", num_cases, mask_cnt);
      errs++;
    end
    report_result("Mask pulse count", errs);

    $display("Tests passed: %0d, tests with errors: %0d", tests_pass, tests_fail);
    if (tests_fail == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/equihash_verif_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module equihash_verif_top #(
  parameter int HASH_ROUNDS = 3
) (
  input  wire                       i_clk,
  input  wire                       i_rst,
  input  wire equihash_pkg::word_t  i_dat,
  input  wire                       i_dat_val,
  input  wire                       i_dat_eop,
  output equihash_pkg::check_mask_t o_mask,
  output logic                      o_mask_val,
  output logic                      o_busy
);

  equihash_pkg::header_t   header;
  equihash_pkg::sol_cnt_t  wr_cnt;
  logic                    done;
  logic                    w_req, w_gnt, r_req, r_gnt;
  equihash_pkg::sol_addr_t w_addr, r_addr, ram_addr;
  equihash_pkg::word_t     w_dat, r_dat, ram_wdat, ram_rdat;
  logic                    ram_we;
  logic                    idx_val, hash_val;
  equihash_pkg::idx_t      idx;
  equihash_pkg::hash_t     hash;

  sol_loader loader_i (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_dat(i_dat), .i_dat_val(i_dat_val), .i_dat_eop(i_dat_eop),
    .i_done(done), .o_header(header), .o_wr_cnt(wr_cnt), .o_busy(o_busy),
    .o_w_req(w_req), .o_w_addr(w_addr), .o_w_dat(w_dat), .i_w_gnt(w_gnt)
  );

  sol_checker checker_i (
    .i_clk(i_clk), .i_rst(i_rst), .i_wr_cnt(wr_cnt),
    .o_r_req(r_req), .o_r_addr(r_addr), .i_r_gnt(r_gnt), .i_r_dat(r_dat),
    .o_idx_val(idx_val), .o_idx(idx), .i_hash_val(hash_val), .i_hash(hash),
    .o_mask(o_mask), .o_mask_val(o_mask_val), .o_done(done)
  );

  ram_arbiter arbiter_i (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_w_req(w_req), .i_w_addr(w_addr), .i_w_dat(w_dat), .o_w_gnt(w_gnt),
    .i_r_req(r_req), .i_r_addr(r_addr), .o_r_gnt(r_gnt), .o_r_dat(r_dat),
    .o_ram_we(ram_we), .o_ram_addr(ram_addr), .o_ram_wdat(ram_wdat), .i_ram_rdat(ram_rdat)
  );

  sol_ram ram_i (
    .i_clk(i_clk), .i_rst(i_rst), .i_we(ram_we), .i_addr(ram_addr),
    .i_wdat(ram_wdat), .o_rdat(ram_rdat)
  );

  index_hasher #(.HASH_ROUNDS(HASH_ROUNDS)) hasher_i (
    .i_clk(i_clk), .i_rst(i_rst), .i_header(header),
    .i_idx_val(idx_val), .i_idx(idx), .o_hash_val(hash_val), .o_hash(hash)
  );

endmodule

`default_nettype wire

// ==== hw/sol_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module sol_checker (
  input  wire                          i_clk,
  input  wire                          i_rst,
  input  wire equihash_pkg::sol_cnt_t  i_wr_cnt,
  output logic                         o_r_req,
  output equihash_pkg::sol_addr_t      o_r_addr,
  input  wire                          i_r_gnt,
  input  wire equihash_pkg::word_t     i_r_dat,
  output logic                         o_idx_val,
  output equihash_pkg::idx_t           o_idx,
  input  wire                          i_hash_val,
  input  wire equihash_pkg::hash_t     i_hash,
  output equihash_pkg::check_mask_t    o_mask,
  output logic                         o_mask_val,
  output logic                         o_done
);

  typedef enum logic [1:0] {IDLE, READ, UNPACK, WAIT} chk_state_t;

  chk_state_t                                         state;
  equihash_pkg::sol_addr_t                            rd_addr;
  logic                                               rd_wait;
  equihash_pkg::word_t                                word_q;
  logic [$clog2(equihash_pkg::IDX_PER_WORD)-1:0]      byte_sel;
  equihash_pkg::idx_t                                 even_idx;
  logic [2**equihash_pkg::IDX_BITS-1:0]               seen;
  logic                                               dup_fnd;
  logic                                               order_bad;
  equihash_pkg::hash_t                                hash_xor;
  logic [$clog2(equihash_pkg::SOL_LEN)-1:0]           hash_cnt;

  // Only ask for a word once the loader has written it
  assign o_r_req   = (state == READ) && !rd_wait &&
                     (i_wr_cnt > equihash_pkg::sol_cnt_t'(rd_addr));
  assign o_r_addr  = rd_addr;
  assign o_idx     = word_q[byte_sel*equihash_pkg::IDX_BITS +: equihash_pkg::IDX_BITS];
  assign o_idx_val = (state == UNPACK);
  assign o_done    = o_mask_val;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= IDLE;
      rd_addr  <= '0;
      rd_wait  <= 1'b0;
      byte_sel <= '0;
    end else begin
      case (state)
        IDLE: begin
          rd_addr  <= '0;
          byte_sel <= '0;
          if (i_wr_cnt != '0) begin
            state <= READ;
          end
        end
        READ: begin
          if (i_r_gnt) begin
            rd_wait <= 1'b1;
          end
          // Data shows up the cycle after the grant
          if (rd_wait) begin
            rd_wait  <= 1'b0;
            byte_sel <= '0;
            state    <= UNPACK;
          end
        end
        UNPACK: begin
          byte_sel <= byte_sel + 1'b1;
          if (byte_sel == equihash_pkg::IDX_PER_WORD - 1) begin
            if (rd_addr == equihash_pkg::SOL_WORDS - 1) begin
              state <= WAIT;
            end else begin
              rd_addr <= rd_addr + 1'b1;
              state   <= READ;
            end
          end
        end
        WAIT: begin
          // Leave only after the loader has seen done and cleared its count
          if (o_mask_val) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state == READ && rd_wait) begin
      word_q <= i_r_dat;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_mask_val <= 1'b0;
    end else begin
      o_mask_val <= 1'b0;
      if (state == IDLE) begin
        seen      <= '0;
        dup_fnd   <= 1'b0;
        order_bad <= 1'b0;
        hash_xor  <= '0;
        hash_cnt  <= '0;
      end
      if (o_idx_val) begin
        seen[o_idx] <= 1'b1;
        dup_fnd     <= dup_fnd | seen[o_idx];
        // Even byte lanes hold the first index of a leaf pair
        if (!byte_sel[0]) begin
          even_idx <= o_idx;
        end else if (even_idx >= o_idx) begin
          order_bad <= 1'b1;
        end
      end
      if (i_hash_val) begin
        hash_xor <= hash_xor ^ i_hash;
        hash_cnt <= hash_cnt + 1'b1;
        if (hash_cnt == equihash_pkg::SOL_LEN - 1) begin
          o_mask[equihash_pkg::MASK_XOR_NZ]    <= |(hash_xor ^ i_hash);
          o_mask[equihash_pkg::MASK_ORDER_BAD] <= order_bad;
          o_mask[equihash_pkg::MASK_DUP_FND]   <= dup_fnd;
          o_mask_val <= 1'b1;
        end
      end
    end
  end

  a_rd_after_wr: assert property (
    @(posedge i_clk) disable iff (i_rst)
    i_r_gnt |-> i_wr_cnt > equihash_pkg::sol_cnt_t'(o_r_addr)
  ) else $error("Checker read a RAM word that was not written yet");

endmodule

`default_nettype wire

// ==== hw/index_hasher.sv ====
`timescale 1ns/1ns
`default_nettype none

module index_hasher #(
  parameter int HASH_ROUNDS = 3
) (
  input  wire                        i_clk,
  input  wire                        i_rst,
  input  wire equihash_pkg::header_t i_header,
  input  wire                        i_idx_val,
  input  wire equihash_pkg::idx_t    i_idx,
  output logic                       o_hash_val,
  output equihash_pkg::hash_t        o_hash
);

  localparam int NUM_SLICES = $bits(equihash_pkg::header_t) / equihash_pkg::HASH_BITS;
  localparam int ROT        = 5;

  logic                stg_val  [HASH_ROUNDS];
  equihash_pkg::hash_t stg_hash [HASH_ROUNDS];
  equihash_pkg::idx_t  stg_idx  [HASH_ROUNDS];

  // One mixing round adds the key slice, rotates left and folds the index back in
  function automatic equihash_pkg::hash_t mix_round(equihash_pkg::hash_t st,
                                                    equihash_pkg::idx_t  idx,
                                                    equihash_pkg::hash_t key);
    equihash_pkg::hash_t sum;
    sum = st + key;
    return {sum[equihash_pkg::HASH_BITS-ROT-1:0],
            sum[equihash_pkg::HASH_BITS-1:equihash_pkg::HASH_BITS-ROT]}
           ^ equihash_pkg::hash_t'(idx);
  endfunction

  function automatic equihash_pkg::hash_t key_slice(equihash_pkg::header_t hdr, int r);
    return hdr[(r % NUM_SLICES)*equihash_pkg::HASH_BITS +: equihash_pkg::HASH_BITS];
  endfunction

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int r = 0; r < HASH_ROUNDS; r++) begin
        stg_val[r] <= 1'b0;
      end
    end else begin
      stg_val[0] <= i_idx_val;
      for (int r = 1; r < HASH_ROUNDS; r++) begin
        stg_val[r] <= stg_val[r-1];
      end
    end
  end

  // The index rides beside the state so every stage can use it
  always_ff @(posedge i_clk) begin
    stg_idx[0]  <= i_idx;
    stg_hash[0] <= mix_round(equihash_pkg::hash_t'(i_idx), i_idx, key_slice(i_header, 0));
    for (int r = 1; r < HASH_ROUNDS; r++) begin
      stg_idx[r]  <= stg_idx[r-1];
      stg_hash[r] <= mix_round(stg_hash[r-1], stg_idx[r-1], key_slice(i_header, r));
    end
  end

  assign o_hash_val = stg_val[HASH_ROUNDS-1];
  assign o_hash     = stg_hash[HASH_ROUNDS-1];

endmodule

`default_nettype wire

// ==== hw/sol_loader.sv ====
`timescale 1ns/1ns
`default_nettype none

module sol_loader (
  input  wire                          i_clk,
  input  wire                          i_rst,
  input  wire equihash_pkg::word_t     i_dat,
  input  wire                          i_dat_val,
  input  wire                          i_dat_eop,
  input  wire                          i_done,
  output equihash_pkg::header_t        o_header,
  output equihash_pkg::sol_cnt_t       o_wr_cnt,
  output logic                         o_busy,
  output logic                         o_w_req,
  output equihash_pkg::sol_addr_t      o_w_addr,
  output equihash_pkg::word_t          o_w_dat,
  input  wire                          i_w_gnt
);

  typedef enum logic [1:0] {IDLE, HDR, SOL, WAIT} ld_state_t;

  ld_state_t  state;
  // Position of the next stream word, 0 to 7
  logic [$clog2(equihash_pkg::HDR_WORDS+equihash_pkg::SOL_WORDS)-1:0] wrd_pos;

  // Busy drops together with the mask pulse
  assign o_busy = (state != IDLE) && !i_done;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= IDLE;
      wrd_pos  <= '0;
      o_wr_cnt <= '0;
      o_w_req  <= 1'b0;
    end else begin
      if (i_w_gnt) begin
        o_w_req  <= 1'b0;
        o_wr_cnt <= o_wr_cnt + 1'b1;
      end
      case (state)
        IDLE: begin
          if (i_dat_val) begin
            o_header[0 +: equihash_pkg::WORD_BITS] <= i_dat;
            wrd_pos <= 3'd1;
            state   <= HDR;
          end
        end
        HDR: begin
          if (i_dat_val) begin
            o_header[wrd_pos[1:0]*equihash_pkg::WORD_BITS +: equihash_pkg::WORD_BITS] <= i_dat;
            wrd_pos <= wrd_pos + 1'b1;
            if (wrd_pos == equihash_pkg::HDR_WORDS - 1) begin
              state <= SOL;
            end
          end
        end
        SOL: begin
          // A pending write is granted in the cycle it is raised, so a new word never
          // overwrites one that is still waiting
          if (i_dat_val) begin
            o_w_req  <= 1'b1;
            o_w_addr <= equihash_pkg::sol_addr_t'(wrd_pos);
            o_w_dat  <= i_dat;
            wrd_pos  <= wrd_pos + 1'b1;
            if (i_dat_eop) begin
              state <= WAIT;
            end
          end
        end
        WAIT: begin
          if (i_done) begin
            o_wr_cnt <= '0;
            // The host may start the next header in the very cycle busy falls
            if (i_dat_val) begin
              o_header[0 +: equihash_pkg::WORD_BITS] <= i_dat;
              wrd_pos <= 3'd1;
              state   <= HDR;
            end else begin
              wrd_pos <= '0;
              state   <= IDLE;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  a_eop_on_last: assert property (
    @(posedge i_clk) disable iff (i_rst)
    i_dat_val && i_dat_eop |-> state == SOL && wrd_pos == 3'd7
  ) else $error("eop seen on a word other than the eighth");

  a_no_word_busy: assert property (
    @(posedge i_clk) disable iff (i_rst)
    i_dat_val |-> !(state == WAIT && !i_done)
  ) else $error("Input word arrived while the previous solution is checked");

endmodule

`default_nettype wire

// ==== hw/ram_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module ram_arbiter (
  input  wire                          i_clk,
  input  wire                          i_rst,
  // Loader write port
  input  wire                          i_w_req,
  input  wire equihash_pkg::sol_addr_t i_w_addr,
  input  wire equihash_pkg::word_t     i_w_dat,
  output logic                         o_w_gnt,
  // Checker read port
  input  wire                          i_r_req,
  input  wire equihash_pkg::sol_addr_t i_r_addr,
  output logic                         o_r_gnt,
  output equihash_pkg::word_t          o_r_dat,
  // Toward the solution RAM
  output logic                         o_ram_we,
  output equihash_pkg::sol_addr_t      o_ram_addr,
  output equihash_pkg::word_t          o_ram_wdat,
  input  wire equihash_pkg::word_t     i_ram_rdat
);

  // The loader always wins and a read only goes through on a cycle without a write
  assign o_w_gnt = i_w_req;
  assign o_r_gnt = i_r_req && !i_w_req;

  assign o_ram_we   = o_w_gnt;
  assign o_ram_addr = i_w_req ? i_w_addr : i_r_addr;
  assign o_ram_wdat = i_w_dat;

  // RAM output register already gives the one cycle read latency
  assign o_r_dat = i_ram_rdat;

  a_one_grant: assert property (
    @(posedge i_clk) disable iff (i_rst)
    !(o_w_gnt && o_r_gnt)
  ) else $error("RAM granted to loader and checker in the same cycle");

endmodule

`default_nettype wire

// ==== hw/sol_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module sol_ram (
  input  wire                     i_clk,
  input  wire                     i_rst,
  input  wire                     i_we,
  input  wire equihash_pkg::sol_addr_t i_addr,
  input  wire equihash_pkg::word_t     i_wdat,
  output equihash_pkg::word_t     o_rdat
);

  equihash_pkg::word_t mem [equihash_pkg::SOL_WORDS];

  always_ff @(posedge i_clk) begin
    if (i_we) begin
      mem[i_addr] <= i_wdat;
    end
  end

  // The read is registered so data is valid one cycle after the address
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_rdat <= '0;
    end else begin
      o_rdat <= mem[i_addr];
    end
  end

endmodule

`default_nettype wire

// ==== hw/equihash_pkg.sv ====
`default_nettype none

package equihash_pkg;

  // Stream and solution geometry
  localparam int WORD_BITS    = 32;
  localparam int HDR_WORDS    = 4;
  localparam int SOL_WORDS    = 4;
  localparam int IDX_BITS     = 8;
  localparam int SOL_LEN      = 16;
  localparam int HASH_BITS    = 16;
  localparam int IDX_PER_WORD = 4;

  // Bit positions inside the result mask
  localparam int MASK_XOR_NZ    = 0;
  localparam int MASK_ORDER_BAD = 1;
  localparam int MASK_DUP_FND   = 2;

  typedef logic [WORD_BITS-1:0]             word_t;
  // Header word 0 sits in the low bits
  typedef logic [HDR_WORDS*WORD_BITS-1:0]   header_t;
  typedef logic [IDX_BITS-1:0]              idx_t;
  typedef logic [HASH_BITS-1:0]             hash_t;
  typedef logic [$clog2(SOL_WORDS)-1:0]     sol_addr_t;
  // Needs one extra value so a full solution (4 words) can be counted
  typedef logic [$clog2(SOL_WORDS+1)-1:0]   sol_cnt_t;
  typedef logic [2:0]                       check_mask_t;

endpackage

`default_nettype wire
